// ==== Makefile ====
# Verilator simulation of the acquisition core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

.PHONY: sim clean

# build and run, exit status follows the testbench result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+tests
source/rp_pkg.sv
source/adc_frontend.sv
source/lin_calib.sv
source/dac_backend.sv
source/pdm_mod.sv
source/debounce.sv
source/rp_core_top.sv
tests/tb_top.sv

// ==== source/adc_frontend.sv ====
////////////////////////////////////////////////////////////
// ADC input register and loopback mux
////////////////////////////////////////////////////////////

module adc_frontend
  import rp_pkg::*;
#(
  // number of analog channels
  parameter int unsigned CHN = 2
)(
  input  logic               adc_clk,
  input  logic               rst,
  // raw words from the converter
  input  smp_t     [CHN-1:0] adc_dat_i,
  // per channel loopback select
  input  logic     [CHN-1:0] mux_loop_i,
  // calibrated generator samples
  input  smp_t     [CHN-1:0] dac_cal_i,
  // samples toward the ADC calibration
  output smp_t     [CHN-1:0] adc_smp_o
);

// registered and reformatted ADC samples
smp_t [CHN-1:0] adc_smp;

////////////////////////////////////////////////////////////
// input register
////////////////////////////////////////////////////////////

// converter delivers offset binary with negative slope
// flipping the low bits gives two's complement
always_ff @(posedge adc_clk, posedge rst) begin
  if (rst) begin
    adc_smp <= '0;
  end else begin
    for (int i = 0; i < CHN; i++) begin
      adc_smp[i] <= flip_smp(adc_dat_i[i]);
    end
  end
end

////////////////////////////////////////////////////////////
// digital loopback
////////////////////////////////////////////////////////////

// channel i of the DAC loops into channel i of the ADC
always_comb begin
  for (int i = 0; i < CHN; i++) begin
    adc_smp_o[i] = mux_loop_i[i] ? dac_cal_i[i] : adc_smp[i];
  end
end

endmodule: adc_frontend

// ==== source/dac_backend.sv ====
////////////////////////////////////////////////////////////
// DAC calibration and code register
////////////////////////////////////////////////////////////

module dac_backend
  import rp_pkg::*;
#(
  // number of analog channels
  parameter int unsigned CHN = 2
)(
  input  logic                       adc_clk,
  input  logic                       rst,
  // generator samples
  input  smp_t     [CHN-1:0]         gen_dat_i,
  // calibration per channel
  input  cal_mul_t [CHN-1:0]         dac_cfg_mul_i,
  input  cal_sum_t [CHN-1:0]         dac_cfg_sum_i,
  // calibrated samples, toward loopback
  output smp_t     [CHN-1:0]         dac_cal_o,
  // DAC codes, parallel word per channel
  output logic     [CHN-1:0][SMP_W-1:0] dac_dat_o
);

////////////////////////////////////////////////////////////
// calibration
////////////////////////////////////////////////////////////

for (genvar i = 0; i < CHN; i++) begin: g_cal
  lin_calib u_cal (
    .adc_clk (adc_clk),
    .rst     (rst),
    .smp_i   (gen_dat_i[i]),
    .mul_i   (dac_cfg_mul_i[i]),
    .sum_i   (dac_cfg_sum_i[i]),
    .smp_o   (dac_cal_o[i])
  );
end: g_cal

////////////////////////////////////////////////////////////
// code register
////////////////////////////////////////////////////////////

// negative slope offset binary
// reset value is the code of a zero sample
always_ff @(posedge adc_clk, posedge rst) begin
  if (rst) begin
    for (int i = 0; i < CHN; i++) begin
      dac_dat_o[i] <= flip_smp(smp_t'(0));
    end
  end else begin
    for (int i = 0; i < CHN; i++) begin
      dac_dat_o[i] <= flip_smp(dac_cal_o[i]);
    end
  end
end

endmodule: dac_backend

// ==== source/debounce.sv ====
////////////////////////////////////////////////////////////
// pin debouncer with edge events
////////////////////////////////////////////////////////////

module debounce #(
  // lockout length in clock cycles
  parameter int unsigned DEB_LEN = 62500
)(
  input  logic adc_clk,
  input  logic rst,
  // asynchronous pin
  input  logic d_i,
  // accepted edge pulses
  output logic pos_o,
  output logic neg_o
);

localparam int unsigned CNT_W = $clog2(DEB_LEN + 1);

typedef enum logic {
  DEB_IDLE,
  DEB_LOCK
} deb_state_e;

deb_state_e       state;
logic [CNT_W-1:0] cnt;
// synchronizer pair
logic             d_s1;
logic             d_s2;
// stable value and its previous copy
logic             stb;
logic             stb_d;

////////////////////////////////////////////////////////////
// synchronizer, FSM and lockout counter
////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk, posedge rst) begin
  if (rst) begin
    d_s1  <= 1'b0;
    d_s2  <= 1'b0;
    stb   <= 1'b0;
    cnt   <= '0;
    state <= DEB_IDLE;
  end else begin
    d_s1 <= d_i;
    d_s2 <= d_s1;
    case (state)
      DEB_IDLE: begin
        // take the change, then ignore the pin for a while
        if (d_s2 != stb) begin
          stb   <= d_s2;
          cnt   <= CNT_W'(DEB_LEN);
          state <= DEB_LOCK;
        end
      end
      DEB_LOCK: begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) state <= DEB_IDLE;
      end
      default: state <= DEB_IDLE;
    endcase
  end
end

// one cycle pulse per accepted edge
always_ff @(posedge adc_clk, posedge rst) begin
  if (rst) begin
    stb_d <= 1'b0;
    pos_o <= 1'b0;
    neg_o <= 1'b0;
  end else begin
    stb_d <= stb;
    pos_o <= stb & ~stb_d;
    neg_o <= ~stb & stb_d;
  end
end

endmodule: debounce

// ==== source/lin_calib.sv ====
////////////////////////////////////////////////////////////
// gain, offset and saturation stage
////////////////////////////////////////////////////////////

module lin_calib
  import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst,
  // sample in
  input  smp_t     smp_i,
  // gain, MUL_FRAC fractional bits
  input  cal_mul_t mul_i,
  // offset
  input  cal_sum_t sum_i,
  // calibrated sample out
  output smp_t     smp_o
);

// full product width
localparam int PRD_W = SMP_W + MUL_W;
// product after scaling
localparam int SCL_W = PRD_W - MUL_FRAC;
// one guard bit for the offset add
localparam int SUM_W = SCL_W + 1;

logic signed [PRD_W-1:0] prd;
logic signed [SCL_W-1:0] prd_scl;
logic signed [SUM_W-1:0] sum;
smp_t                    sat;

////////////////////////////////////////////////////////////
// arithmetic
////////////////////////////////////////////////////////////

// signed multiply at full width, no rounding
assign prd = smp_i * mul_i;

// drop fractional bits
// slicing off the low bits is floor division
assign prd_scl = prd[PRD_W-1:MUL_FRAC];

// offset add, sign extended into the guard bit
assign sum = prd_scl + sum_i;

// clamp to the sample range
always_comb begin
  if (sum > SMP_MAX) begin
    sat = SMP_MAX;
  end else if (sum < SMP_MIN) begin
    sat = SMP_MIN;
  end else begin
    sat = sum[SMP_W-1:0];
  end
end

////////////////////////////////////////////////////////////
// output register
////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk, posedge rst) begin
  if (rst) begin
    smp_o <= '0;
  end else begin
    smp_o <= sat;
  end
end

endmodule: lin_calib

// ==== source/pdm_mod.sv ====
////////////////////////////////////////////////////////////
// first order PDM modulator
////////////////////////////////////////////////////////////

module pdm_mod
  import rp_pkg::*;
#(
  // number of PDM outputs
  parameter int unsigned PDM_CHN = 4
)(
  input  logic                     adc_clk,
  input  logic                     rst,
  // density levels, 0 to PDM_RNG
  input  pdm_lvl_t [PDM_CHN-1:0]   lvl_i,
  // modulated bit streams
  output logic     [PDM_CHN-1:0]   pdm_o
);

// accumulator plus level needs one carry bit
localparam int ACC_W = PDM_W + 1;

// residue kept below PDM_RNG
pdm_lvl_t [PDM_CHN-1:0]            acc;
pdm_lvl_t [PDM_CHN-1:0]            acc_nxt;
logic     [PDM_CHN-1:0][ACC_W-1:0] sum;
logic     [PDM_CHN-1:0]            bit_nxt;

////////////////////////////////////////////////////////////
// next state
////////////////////////////////////////////////////////////

// a one is emitted whenever the sum reaches the modulus
// the modulus is then taken back out of the residue
always_comb begin
  for (int i = 0; i < PDM_CHN; i++) begin
    sum[i]     = {1'b0, acc[i]} + {1'b0, lvl_i[i]};
    bit_nxt[i] = (sum[i] >= ACC_W'(PDM_RNG));
    if (bit_nxt[i]) begin
      acc_nxt[i] = PDM_W'(sum[i] - ACC_W'(PDM_RNG));
    end else begin
      acc_nxt[i] = sum[i][PDM_W-1:0];
    end
  end
end

////////////////////////////////////////////////////////////
// registers
////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk, posedge rst) begin
  if (rst) begin
    acc   <= '0;
    pdm_o <= '0;
  end else begin
    acc   <= acc_nxt;
    pdm_o <= bit_nxt;
  end
end

endmodule: pdm_mod

// ==== source/rp_core_top.sv ====
////////////////////////////////////////////////////////////
// acquisition and generation core
// ADC, DAC, PDM and expansion pin paths
////////////////////////////////////////////////////////////

module rp_core_top
  import rp_pkg::*;
#(
  // analog channels, shared by ADC and DAC for loopback
  parameter int unsigned CHN     = 2,
  // PDM outputs
  parameter int unsigned PDM_CHN = 4,
  // debounce lockout in cycles
  parameter int unsigned DEB_LEN = 62500
)(
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // ADC
  input  smp_t     [CHN-1:0]            adc_dat_i,
  input  cal_mul_t [CHN-1:0]            adc_cfg_mul_i,
  input  cal_sum_t [CHN-1:0]            adc_cfg_sum_i,
  output smp_t     [CHN-1:0]            adc_dat_o,
  // DAC
  input  cal_mul_t [CHN-1:0]            dac_cfg_mul_i,
  input  cal_sum_t [CHN-1:0]            dac_cfg_sum_i,
  input  logic     [CHN-1:0]            mux_loop_i,
  input  smp_t     [CHN-1:0]            gen_dat_i,
  output logic     [CHN-1:0][SMP_W-1:0] dac_dat_o,
  // PDM
  input  pdm_lvl_t [PDM_CHN-1:0]        pdm_lvl_i,
  output logic     [PDM_CHN-1:0]        dac_pwm_o,
  // expansion pin
  input  logic                          gio_i,
  output logic                          gio_pos_o,
  output logic                          gio_neg_o
);

logic           rst;
// ADC samples after input register and loopback mux
smp_t [CHN-1:0] adc_smp;
// calibrated generator samples
smp_t [CHN-1:0] dac_cal;

////////////////////////////////////////////////////////////
// reset
////////////////////////////////////////////////////////////

// asserted at once, released on a clock edge
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) rst <= 1'b1;
  else         rst <= 1'b0;
end

////////////////////////////////////////////////////////////
// ADC path
////////////////////////////////////////////////////////////

adc_frontend #(
  .CHN (CHN)
) u_adc_fe (
  .adc_clk    (adc_clk),
  .rst        (rst),
  .adc_dat_i  (adc_dat_i),
  .mux_loop_i (mux_loop_i),
  .dac_cal_i  (dac_cal),
  .adc_smp_o  (adc_smp)
);

for (genvar i = 0; i < CHN; i++) begin: g_adc_cal
  lin_calib u_cal (
    .adc_clk (adc_clk),
    .rst     (rst),
    .smp_i   (adc_smp[i]),
    .mul_i   (adc_cfg_mul_i[i]),
    .sum_i   (adc_cfg_sum_i[i]),
    .smp_o   (adc_dat_o[i])
  );
end: g_adc_cal

////////////////////////////////////////////////////////////
// DAC path
////////////////////////////////////////////////////////////

dac_backend #(
  .CHN (CHN)
) u_dac_be (
  .adc_clk       (adc_clk),
  .rst           (rst),
  .gen_dat_i     (gen_dat_i),
  .dac_cfg_mul_i (dac_cfg_mul_i),
  .dac_cfg_sum_i (dac_cfg_sum_i),
  .dac_cal_o     (dac_cal),
  .dac_dat_o     (dac_dat_o)
);

////////////////////////////////////////////////////////////
// PDM outputs and expansion pin
////////////////////////////////////////////////////////////

pdm_mod #(
  .PDM_CHN (PDM_CHN)
) u_pdm (
  .adc_clk (adc_clk),
  .rst     (rst),
  .lvl_i   (pdm_lvl_i),
  .pdm_o   (dac_pwm_o)
);

debounce #(
  .DEB_LEN (DEB_LEN)
) u_deb (
  .adc_clk (adc_clk),
  .rst     (rst),
  .d_i     (gio_i),
  .pos_o   (gio_pos_o),
  .neg_o   (gio_neg_o)
);

endmodule: rp_core_top

// ==== source/rp_pkg.sv ====
////////////////////////////////////////////////////////////
// analog path shared types
////////////////////////////////////////////////////////////

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // samples
  ////////////////////////////////////////////////////////////

  // ADC and DAC word width
  localparam int SMP_W = 14;

  // signed sample, used on both ADC and generator side
  typedef logic signed [SMP_W-1:0] smp_t;

  // saturation limits of the sample range
  localparam smp_t SMP_MAX = smp_t'(2**(SMP_W-1) - 1);
  localparam smp_t SMP_MIN = smp_t'(-(2**(SMP_W-1)));

  // sign kept, magnitude bits inverted
  // the same mapping converts raw ADC words and builds DAC codes
  function automatic smp_t flip_smp(input smp_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // calibration
  ////////////////////////////////////////////////////////////

  // gain word, 1.0 is 2**MUL_FRAC
  localparam int MUL_W    = 16;
  localparam int MUL_FRAC = 14;

  typedef logic signed [MUL_W-1:0] cal_mul_t;
  // offset, same scale as the sample
  typedef logic signed [SMP_W-1:0] cal_sum_t;

  ////////////////////////////////////////////////////////////
  // PDM
  ////////////////////////////////////////////////////////////

  localparam int          PDM_W   = 8;
  // modulus, full scale level gives a constant one
  localparam int unsigned PDM_RNG = 255;

  typedef logic [PDM_W-1:0] pdm_lvl_t;

endpackage: rp_pkg

// ==== tests/tb_tasks.svh ====
////////////////////////////////////////////////////////////
// testbench helpers and reference models
////////////////////////////////////////////////////////////

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// LFSR state seeded once
logic [31:0] rng_state = 32'd72085;

// low bits below the sign
localparam logic [SMP_W-1:0] MAG_MASK = {1'b0, {(SMP_W-1){1'b1}}};

////////////////////////////////////////////////////////////
// random numbers
////////////////////////////////////////////////////////////

// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int k = 0; k < n; k++) begin
    fb        = rng_state[31] ^ rng_state[21] ^ rng_state[1] ^ rng_state[0];
    rng_state = {rng_state[30:0], fb};
    val       = {val[30:0], fb};
  end
  return val;
endfunction

////////////////////////////////////////////////////////////
// compare and report
////////////////////////////////////////////////////////////

task automatic check_value(input string name, input logic signed [63:0] exp_v,
                           input logic signed [63:0] act_v);
  if (exp_v !== act_v) begin
    $display("Fail %s: expected %0d, actual %0d", name, exp_v, act_v);
    $display("Test failures found");
    $fatal(1, "value mismatch in %s", name);
  end
endtask

////////////////////////////////////////////////////////////
// reference models
////////////////////////////////////////////////////////////

// raw word to signed sample with the sign kept and the magnitude inverted
function automatic longint fmt_ref(input logic [SMP_W-1:0] raw);
  smp_t v;
  v = raw ^ MAG_MASK;
  return v;
endfunction

// sample to DAC code by the same bit rule read as unsigned
function automatic longint code_ref(input longint smp);
  logic [SMP_W-1:0] w;
  w = smp[SMP_W-1:0] ^ MAG_MASK;
  return longint'(w);
endfunction

// gain, floor scaling, offset, clamp
function automatic longint cal_ref(input longint x, input longint m, input longint s);
  longint unit;
  longint prd;
  longint scl;
  longint res;
  longint lim_hi;
  longint lim_lo;
  unit   = 1 << MUL_FRAC;
  lim_hi = (1 << (SMP_W - 1)) - 1;
  lim_lo = -(1 << (SMP_W - 1));
  prd    = x * m;
  scl    = prd / unit;
  // division truncates toward zero so negative remainders step down
  if (prd < 0 && (prd % unit) != 0) scl = scl - 1;
  res = scl + s;
  if (res > lim_hi) res = lim_hi;
  else if (res < lim_lo) res = lim_lo;
  return res;
endfunction

`endif

// ==== tests/tb_top.sv ====
////////////////////////////////////////////////////////////
// acquisition core testbench
////////////////////////////////////////////////////////////

module tb_top
  import rp_pkg::*;
();

localparam int CHN     = 2;
localparam int PDM_CHN = 4;
localparam int DEB_LEN = 16;
localparam int CLK_PER = 4;

////////////////////////////////////////////////////////////
// cycle budget per test for the watchdog
////////////////////////////////////////////////////////////

localparam int UNITY_VEC = 8;
localparam int ADC_VEC   = 24;
localparam int DAC_VEC   = 16;
localparam int LOOP_VEC  = 16;
localparam int PDM_SETS  = 5;
localparam int RST_CYC   = 8;
localparam int DEB_CYC   = 40;
localparam int MARGIN    = 100;
localparam int TOTAL_CYC = RST_CYC + 2 * (ADC_VEC + DAC_VEC + LOOP_VEC)
                         + PDM_SETS * (PDM_RNG + 1) + DEB_CYC + MARGIN;

logic                          adc_clk = 1'b0;
logic                          top_rst;
smp_t     [CHN-1:0]            adc_dat_i;
cal_mul_t [CHN-1:0]            adc_cfg_mul_i;
cal_sum_t [CHN-1:0]            adc_cfg_sum_i;
smp_t     [CHN-1:0]            adc_dat_o;
cal_mul_t [CHN-1:0]            dac_cfg_mul_i;
cal_sum_t [CHN-1:0]            dac_cfg_sum_i;
logic     [CHN-1:0]            mux_loop_i;
smp_t     [CHN-1:0]            gen_dat_i;
logic     [CHN-1:0][SMP_W-1:0] dac_dat_o;
pdm_lvl_t [PDM_CHN-1:0]        pdm_lvl_i;
logic     [PDM_CHN-1:0]        dac_pwm_o;
logic                          gio_i;
logic                          gio_pos_o;
logic                          gio_neg_o;

// edge pulse counters of the debounce test
int pos_cnt;
int neg_cnt;

`include "tb_tasks.svh"

rp_core_top #(
  .CHN     (CHN),
  .PDM_CHN (PDM_CHN),
  .DEB_LEN (DEB_LEN)
) DUT (
  .adc_clk       (adc_clk),
  .top_rst       (top_rst),
  .adc_dat_i     (adc_dat_i),
  .adc_cfg_mul_i (adc_cfg_mul_i),
  .adc_cfg_sum_i (adc_cfg_sum_i),
  .adc_dat_o     (adc_dat_o),
  .dac_cfg_mul_i (dac_cfg_mul_i),
  .dac_cfg_sum_i (dac_cfg_sum_i),
  .mux_loop_i    (mux_loop_i),
  .gen_dat_i     (gen_dat_i),
  .dac_dat_o     (dac_dat_o),
  .pdm_lvl_i     (pdm_lvl_i),
  .dac_pwm_o     (dac_pwm_o),
  .gio_i         (gio_i),
  .gio_pos_o     (gio_pos_o),
  .gio_neg_o     (gio_neg_o)
);

always #(CLK_PER / 2) adc_clk = ~adc_clk;

// stimulus changes and outputs are read on falling edges
task automatic next_cycles(input int n);
  repeat (n) @(negedge adc_clk);
endtask

task automatic watch_gio(input int n);
  repeat (n) begin
    @(negedge adc_clk);
    pos_cnt += int'(gio_pos_o);
    neg_cnt += int'(gio_neg_o);
  end
endtask

////////////////////////////////////////////////////////////
// tests
////////////////////////////////////////////////////////////

task automatic test_reset();
  next_cycles(1);
  for (int i = 0; i < CHN; i++) begin
    check_value("reset", 0, $signed(adc_dat_o[i]));
    // code of a zero sample
    check_value("reset", 8191, dac_dat_o[i]);
  end
  check_value("reset", 0, dac_pwm_o);
  check_value("reset", 0, gio_pos_o);
  check_value("reset", 0, gio_neg_o);
endtask

task automatic test_adc_path();
  for (int n = 0; n < ADC_VEC; n++) begin
    for (int i = 0; i < CHN; i++) begin
      if (n < UNITY_VEC) begin
        adc_dat_i[i]     = smp_t'(rand_bits(SMP_W));
        adc_cfg_mul_i[i] = cal_mul_t'(1 << MUL_FRAC);
        adc_cfg_sum_i[i] = '0;
      end else if (n < ADC_VEC - 2) begin
        adc_dat_i[i]     = smp_t'(rand_bits(SMP_W));
        adc_cfg_mul_i[i] = cal_mul_t'(rand_bits(MUL_W));
        adc_cfg_sum_i[i] = cal_sum_t'(rand_bits(SMP_W));
      end else begin
        // full scale words at almost double gain saturate high and low
        adc_dat_i[i]     = (n == ADC_VEC - 2) ? smp_t'(0) : smp_t'(-1);
        adc_cfg_mul_i[i] = cal_mul_t'(16'sh7fff);
        adc_cfg_sum_i[i] = (n == ADC_VEC - 2) ? cal_sum_t'(100) : cal_sum_t'(-100);
      end
    end
    next_cycles(2);
    for (int i = 0; i < CHN; i++) begin
      check_value("adc_path", cal_ref(fmt_ref(adc_dat_i[i]), $signed(adc_cfg_mul_i[i]),
                  $signed(adc_cfg_sum_i[i])), $signed(adc_dat_o[i]));
    end
  end
endtask

task automatic test_dac_path();
  for (int n = 0; n < DAC_VEC; n++) begin
    for (int i = 0; i < CHN; i++) begin
      gen_dat_i[i]     = smp_t'(rand_bits(SMP_W));
      dac_cfg_mul_i[i] = cal_mul_t'(rand_bits(MUL_W));
      dac_cfg_sum_i[i] = cal_sum_t'(rand_bits(SMP_W));
    end
    next_cycles(2);
    for (int i = 0; i < CHN; i++) begin
      check_value("dac_path", code_ref(cal_ref($signed(gen_dat_i[i]),
                  $signed(dac_cfg_mul_i[i]), $signed(dac_cfg_sum_i[i]))), dac_dat_o[i]);
    end
  end
endtask

task automatic test_loopback();
  int     lp;
  longint dac_v;
  longint exp_v;
  for (int n = 0; n < LOOP_VEC; n++) begin
    // loop one channel at a time
    lp             = n % CHN;
    mux_loop_i     = '0;
    mux_loop_i[lp] = 1'b1;
    for (int i = 0; i < CHN; i++) begin
      adc_dat_i[i]     = smp_t'(rand_bits(SMP_W));
      adc_cfg_mul_i[i] = cal_mul_t'(rand_bits(MUL_W));
      adc_cfg_sum_i[i] = cal_sum_t'(rand_bits(SMP_W));
      gen_dat_i[i]     = smp_t'(rand_bits(SMP_W));
      dac_cfg_mul_i[i] = cal_mul_t'(rand_bits(MUL_W));
      dac_cfg_sum_i[i] = cal_sum_t'(rand_bits(SMP_W));
    end
    next_cycles(2);
    for (int i = 0; i < CHN; i++) begin
      dac_v = cal_ref($signed(gen_dat_i[i]), $signed(dac_cfg_mul_i[i]),
                      $signed(dac_cfg_sum_i[i]));
      if (i != lp) dac_v = fmt_ref(adc_dat_i[i]);
      exp_v = cal_ref(dac_v, $signed(adc_cfg_mul_i[i]), $signed(adc_cfg_sum_i[i]));
      check_value("loopback", exp_v, $signed(adc_dat_o[i]));
    end
  end
  mux_loop_i = '0;
endtask

task automatic test_pdm();
  int ones [PDM_CHN];
  int lvl;
  int act;
  for (int s = 0; s < PDM_SETS; s++) begin
    for (int c = 0; c < PDM_CHN; c++) begin
      if (s == 0) pdm_lvl_i[c] = '0;
      else if (s == 1) pdm_lvl_i[c] = pdm_lvl_t'(PDM_RNG);
      else pdm_lvl_i[c] = pdm_lvl_t'(rand_bits(PDM_W));
      ones[c] = 0;
    end
    // one full modulus period
    repeat (PDM_RNG) begin
      @(negedge adc_clk);
      for (int c = 0; c < PDM_CHN; c++) ones[c] += int'(dac_pwm_o[c]);
    end
    for (int c = 0; c < PDM_CHN; c++) begin
      lvl = int'(pdm_lvl_i[c]);
      act = ones[c];
      // slack of one count for the accumulator residue
      if (act == lvl + 1 || act == lvl - 1) act = lvl;
      check_value("pdm", lvl, act);
    end
    next_cycles(1);
  end
endtask

task automatic test_debounce();
  pos_cnt = 0;
  neg_cnt = 0;
  // clean rising edge gives one pulse within 5 cycles
  gio_i = 1'b1;
  watch_gio(5);
  check_value("debounce", 1, pos_cnt);
  check_value("debounce", 0, neg_cnt);
  // bounce inside the lockout that ends low
  gio_i = 1'b0;
  watch_gio(2);
  gio_i = 1'b1;
  watch_gio(2);
  gio_i = 1'b0;
  watch_gio(10);
  check_value("debounce", 1, pos_cnt);
  check_value("debounce", 0, neg_cnt);
  // persistent low level is taken once the lockout ends
  watch_gio(10);
  check_value("debounce", 1, pos_cnt);
  check_value("debounce", 1, neg_cnt);
endtask

////////////////////////////////////////////////////////////
// sequence and watchdog
////////////////////////////////////////////////////////////

initial begin
  top_rst       = 1'b1;
  adc_dat_i     = '0;
  adc_cfg_mul_i = '0;
  adc_cfg_sum_i = '0;
  dac_cfg_mul_i = '0;
  dac_cfg_sum_i = '0;
  mux_loop_i    = '0;
  gen_dat_i     = '0;
  pdm_lvl_i     = '0;
  gio_i         = 1'b0;
  pos_cnt       = 0;
  neg_cnt       = 0;
  next_cycles(3);
  top_rst = 1'b0;
  test_reset();
  test_adc_path();
  test_dac_path();
  test_loopback();
  test_pdm();
  test_debounce();
  $display("All tests passed!");
  $finish;
end

initial begin
  #(TOTAL_CYC * CLK_PER);
  $display("Watchdog expired, the tests did not finish in time");
  $display("Test failures found");
  $fatal(1, "watchdog timeout");
end

endmodule: tb_top
